// File: Makefile
# Verilator build for the TFT init front end

VERILATOR  ?= verilator
TOP        := tft_ctrl_tb
LINT_TOP   := tft_ctrl_top
FILELIST   := tft_ctrl.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
PASS_TEXT  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: bench/tft_ctrl_properties.sv
// ################################################
// serial shifter checks, bound into tft_spi
// ################################################

`timescale 1ns/1ps
`default_nettype none

module tft_ctrl_properties
(
    input wire logic clk,
    input wire logic rst,
    input wire logic start,
    input wire logic busy,
    input wire logic cs,
    input wire logic sclk,
    input wire logic mosi
);

    // no serial clock while the panel is deselected
    sclk_low_when_deselected: assert property (
        @(posedge clk) disable iff (rst) cs |-> !sclk
    ) else $error("sclk is high while cs is high");

    // data only moves on the falling edge
    mosi_stable_when_sclk_high: assert property (
        @(posedge clk) disable iff (rst) sclk |-> $stable(mosi)
    ) else $error("mosi changed while sclk is high");

    // one byte in flight at a time
    start_only_when_free: assert property (
        @(posedge clk) disable iff (rst) busy |-> !start
    ) else $error("start arrived while the shifter was busy");

    // reset leaves the link deselected and the shifter free
    reset_state: assert property (
        @(posedge clk) rst |=> (cs && !sclk && !busy)
    ) else $error("cs, sclk or busy wrong after reset");

endmodule

`default_nettype wire

// File: bench/tft_ctrl_tb.sv
// ################################################
// directed testbench for the tft panel init front end
// with a monitor on the serial link
// ################################################

`timescale 1ns/1ps
`default_nettype none

module tft_ctrl_tb
    import tft_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int CLKS_PER_MS  = 4;
    localparam int SCLK_DIV     = 2;
    localparam int NUM_BYTES    = 42;
    localparam int WAIT_CYCLES  = 255 * CLKS_PER_MS;
    localparam int RUN_LIMIT    = 20000;
    localparam int IDLE_LIMIT   = 2000;
    localparam int PAUSE_CYCLES = 1200;

    // expected stream with the d/c level in bit 8 (0 command, 1 data)
    localparam logic [8:0] EXP_LIST [NUM_BYTES] = '{
        9'h0C0, 9'h117, 9'h115, 9'h0C1, 9'h141, 9'h0C5, 9'h100,
        9'h112, 9'h180, 9'h036, 9'h148, 9'h03A, 9'h166, 9'h0B0,
        9'h180, 9'h0B1, 9'h1A0, 9'h0B6, 9'h102, 9'h102, 9'h0E9,
        9'h100, 9'h0F7, 9'h1A9, 9'h151, 9'h12C, 9'h182, 9'h011,
        9'h029, 9'h021, 9'h034, 9'h02A, 9'h100, 9'h100, 9'h101,
        9'h13F, 9'h02B, 9'h100, 9'h100, 9'h101, 9'h1DF, 9'h02C
    };

    logic clk = 1'b0;
    logic rst;
    logic enable;
    logic spi_cs;
    logic spi_sclk;
    logic spi_mosi;
    logic tft_dc;
    logic init_busy;

    // bytes seen on the link with their d/c level and capture time
    byte_t cap_byte [$];
    logic  cap_dc [$];
    time   cap_time [$];
    int    cs_falls = 0;
    int    mon_bits = 0;
    byte_t mon_shift;

    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    tft_ctrl_top #(
        .CLKS_PER_MS (CLKS_PER_MS),
        .SCLK_DIV    (SCLK_DIV)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .spi_cs    (spi_cs),
        .spi_sclk  (spi_sclk),
        .spi_mosi  (spi_mosi),
        .tft_dc    (tft_dc),
        .init_busy (init_busy)
    );

    bind tft_spi tft_ctrl_properties u_props (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .cs    (cs),
        .sclk  (sclk),
        .mosi  (mosi)
    );

    // a new byte frame starts on each chip select fall
    always @(negedge spi_cs)
    begin
        cs_falls = cs_falls + 1;
        mon_bits = 0;
    end

    // in mode 0 data is sampled on the rising serial clock
    always @(posedge spi_sclk)
    begin
        if (spi_cs === 1'b0)
        begin
            mon_shift = {mon_shift[6:0], spi_mosi};
            mon_bits  = mon_bits + 1;
            if (mon_bits == 8)
            begin
                cap_byte.push_back(mon_shift);
                cap_dc.push_back(tft_dc);
                cap_time.push_back($time);
                mon_bits = 0;
            end
        end
    end

    task automatic report_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
        begin
            $display("test %s: passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic clear_capture();
        cap_byte.delete();
        cap_dc.delete();
        cap_time.delete();
    endtask

    // reset held for 16 cycles while enable keeps its level
    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        if (init_busy !== 1'b0 || spi_cs !== 1'b1)
        begin
            report_error($sformatf("in reset init_busy=%b spi_cs=%b, expected 0 and 1",
                                   init_busy, spi_cs));
        end
        clear_capture();
        rst <= 1'b0;
    endtask

    task automatic wait_bytes(input int n, output bit ok);
        int cycles;
        cycles = 0;
        while (cap_byte.size() < n && cycles < RUN_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        ok = (cap_byte.size() >= n);
        if (!ok)
        begin
            report_failure($sformatf("timed out after %0d cycles waiting for byte %0d",
                                     cycles, n));
        end
    endtask

    // sequencer stopped and link deselected
    task automatic wait_idle(output bit ok);
        int cycles;
        cycles = 0;
        while (!(init_busy === 1'b0 && spi_cs === 1'b1) && cycles < IDLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        ok = (init_busy === 1'b0 && spi_cs === 1'b1);
        if (!ok)
        begin
            report_failure("timed out waiting for init_busy low and chip select high");
        end
    endtask

    task automatic check_stream();
        if (cap_byte.size() != NUM_BYTES)
        begin
            report_error($sformatf("got %0d bytes, expected %0d", cap_byte.size(), NUM_BYTES));
        end
        for (int i = 0; i < cap_byte.size() && i < NUM_BYTES; i++)
        begin
            if (cap_byte[i] !== EXP_LIST[i][7:0] || cap_dc[i] !== EXP_LIST[i][8])
            begin
                report_error($sformatf("byte %0d is %h dc %b, expected %h dc %b", i,
                                       cap_byte[i], cap_dc[i], EXP_LIST[i][7:0],
                                       EXP_LIST[i][8]));
            end
        end
    endtask

    task automatic check_gap(input int first, input int second);
        int gap;
        if (second >= cap_time.size())
        begin
            report_failure($sformatf("byte %0d was never captured, gap not measured", second));
        end
        else
        begin
            gap = int'((cap_time[second] - cap_time[first]) / CLK_PERIOD);
            if (gap < WAIT_CYCLES)
            begin
                report_error($sformatf("gap from byte %0d to %0d is %0d cycles, expected >= %0d",
                                       first, second, gap, WAIT_CYCLES));
            end
        end
    endtask

    task automatic check_full_sequence();
        int errors_before;
        bit ok;
        errors_before = error_count;
        apply_reset();
        @(posedge clk);
        enable <= 1'b1;
        wait_bytes(NUM_BYTES - 1, ok);
        // the last wait and the last command are still ahead
        if (ok && init_busy !== 1'b1)
        begin
            report_error("init_busy is low while table entries remain");
        end
        wait_bytes(NUM_BYTES, ok);
        wait_idle(ok);
        check_stream();
        finish_test("full sequence", errors_before);
    endtask

    // uses the stream captured by the full run
    task automatic measure_wait_gaps();
        int errors_before;
        errors_before = error_count;
        // byte pairs around the waits after 11, 34 and DF
        check_gap(27, 28);
        check_gap(30, 31);
        check_gap(40, 41);
        finish_test("wait gaps", errors_before);
    endtask

    task automatic pause_with_enable();
        int errors_before;
        int stop_at;
        int falls_seen;
        bit ok;
        errors_before = error_count;
        stop_at = 1 + int'($urandom % 40);
        apply_reset();
        @(posedge clk);
        enable <= 1'b1;
        wait_bytes(stop_at, ok);
        enable <= 1'b0;
        // byte in flight finishes
        wait_idle(ok);
        falls_seen = cs_falls;
        repeat (PAUSE_CYCLES) @(posedge clk);
        if (cs_falls != falls_seen)
        begin
            report_failure("chip select fell while enable was low");
        end
        if (init_busy !== 1'b0 || cap_byte.size() != stop_at)
        begin
            report_error($sformatf("paused at %0d bytes with init_busy=%b, expected %0d and 0",
                                   cap_byte.size(), init_busy, stop_at));
        end
        @(posedge clk);
        enable <= 1'b1;
        wait_bytes(NUM_BYTES, ok);
        wait_idle(ok);
        check_stream();
        finish_test($sformatf("enable pause after %0d bytes", stop_at), errors_before);
    endtask

    task automatic restart_after_reset();
        int errors_before;
        bit ok;
        errors_before = error_count;
        apply_reset();
        @(posedge clk);
        enable <= 1'b1;
        wait_bytes(12, ok);
        // enable stays high through the reset
        apply_reset();
        wait_bytes(1, ok);
        if (ok && (cap_byte[0] !== 8'hC0 || cap_dc[0] !== 1'b0))
        begin
            report_error($sformatf("first byte after reset is %h dc %b, expected c0 dc 0",
                                   cap_byte[0], cap_dc[0]));
        end
        wait_bytes(NUM_BYTES, ok);
        wait_idle(ok);
        check_stream();
        finish_test("reset restart", errors_before);
    endtask

    task automatic watch_idle_after_done();
        int errors_before;
        int falls_seen;
        errors_before = error_count;
        if (init_busy !== 1'b0)
        begin
            report_error("init_busy is high after the table completed");
        end
        falls_seen = cs_falls;
        repeat (500) @(posedge clk);
        if (cs_falls != falls_seen || spi_cs !== 1'b1)
        begin
            report_failure("chip select activity after the table completed");
        end
        finish_test("idle after completion", errors_before);
    endtask

    initial
    begin
        rst    <= 1'b1;
        enable <= 1'b0;
        void'($urandom(6));
        check_full_sequence();
        measure_wait_gaps();
        pause_with_enable();
        restart_after_reset();
        watch_idle_after_done();
        $display("tests run: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/ms_delay.sv
// ################################################
// ms_delay: millisecond delay timer, strobe loaded
// ################################################

`timescale 1ns/1ps
`default_nettype none

module ms_delay
    import tft_pkg::*;
#(
    parameter int CLKS_PER_MS = 50000
)
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic load,
    input  wire ms_t  ms,
    output logic      free
);

    localparam int PRE_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(CLKS_PER_MS - 1);

    // clocks left in the current millisecond
    logic [PRE_W-1:0] pre_cnt;
    // milliseconds left, counting the current one
    ms_t              ms_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            free    <= 1'b1;
            pre_cnt <= '0;
            ms_cnt  <= '0;
        end
        else if (load)
        begin
            // a zero length keeps the timer free
            free    <= (ms == '0);
            pre_cnt <= PRE_LAST;
            ms_cnt  <= ms;
        end
        else if (!free)
        begin
            if (pre_cnt != '0)
            begin
                pre_cnt <= pre_cnt - 1'b1;
            end
            else if (ms_cnt <= ms_t'(1))
            begin
                // last millisecond ran out
                free <= 1'b1;
            end
            else
            begin
                ms_cnt  <= ms_cnt - 1'b1;
                pre_cnt <= PRE_LAST;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tft_ctrl_top.sv
// ################################################
// tft_ctrl_top: serial panel init front end
// ################################################

`timescale 1ns/1ps
`default_nettype none

module tft_ctrl_top
    import tft_pkg::*;
#(
    parameter int CLKS_PER_MS = 50000,
    parameter int SCLK_DIV    = 2
)
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic enable,
    output logic      spi_cs,
    output logic      spi_sclk,
    output logic      spi_mosi,
    output logic      tft_dc,
    output logic      init_busy
);

    // sequencer to shifter
    logic  tx_start;
    logic  tx_dc;
    byte_t tx_data;
    logic  tx_busy;

    // sequencer to timer
    logic  delay_load;
    ms_t   delay_ms;
    logic  delay_free;

    tft_init u_init (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .tx_busy    (tx_busy),
        .delay_free (delay_free),
        .tx_start   (tx_start),
        .tx_dc      (tx_dc),
        .tx_data    (tx_data),
        .delay_load (delay_load),
        .delay_ms   (delay_ms),
        .busy       (init_busy)
    );

    ms_delay #(
        .CLKS_PER_MS (CLKS_PER_MS)
    ) u_delay (
        .clk  (clk),
        .rst  (rst),
        .load (delay_load),
        .ms   (delay_ms),
        .free (delay_free)
    );

    tft_spi #(
        .SCLK_DIV (SCLK_DIV)
    ) u_spi (
        .clk    (clk),
        .rst    (rst),
        .start  (tx_start),
        .dc     (tx_dc),
        .data   (tx_data),
        .busy   (tx_busy),
        .cs     (spi_cs),
        .sclk   (spi_sclk),
        .mosi   (spi_mosi),
        .tft_dc (tft_dc)
    );

endmodule

`default_nettype wire

// File: hdl/tft_init.sv
// ################################################
// tft_init: panel init sequencer, walks the table
// ################################################

`timescale 1ns/1ps
`default_nettype none

module tft_init
    import tft_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic enable,
    input  wire logic tx_busy,
    input  wire logic delay_free,
    output logic      tx_start,
    output logic      tx_dc,
    output byte_t     tx_data,
    output logic      delay_load,
    output ms_t       delay_ms,
    output logic      busy
);

    localparam int         TABLE_AW  = $clog2(SEQ_LEN);
    localparam seq_index_t TABLE_END = seq_index_t'(SEQ_LEN);

    localparam seq_entry_t SEQ_TABLE [SEQ_LEN] = '{
        // power-up settle
        {KIND_WAIT, 8'hFF},
        // power control 1
        {KIND_COMM, 8'hC0},
        {KIND_DATA, 8'h17},
        {KIND_DATA, 8'h15},
        // power control 2
        {KIND_COMM, 8'hC1},
        {KIND_DATA, 8'h41},
        // vcom control
        {KIND_COMM, 8'hC5},
        {KIND_DATA, 8'h00},
        {KIND_DATA, 8'h12},
        {KIND_DATA, 8'h80},
        // memory access control
        {KIND_COMM, 8'h36},
        {KIND_DATA, 8'h48},
        // pixel format, 18 bit
        {KIND_COMM, 8'h3A},
        {KIND_DATA, 8'h66},
        // interface mode
        {KIND_COMM, 8'hB0},
        {KIND_DATA, 8'h80},
        // frame rate
        {KIND_COMM, 8'hB1},
        {KIND_DATA, 8'hA0},
        // display function control
        {KIND_COMM, 8'hB6},
        {KIND_DATA, 8'h02},
        {KIND_DATA, 8'h02},
        // set image function
        {KIND_COMM, 8'hE9},
        {KIND_DATA, 8'h00},
        // adjust control 3
        {KIND_COMM, 8'hF7},
        {KIND_DATA, 8'hA9},
        {KIND_DATA, 8'h51},
        {KIND_DATA, 8'h2C},
        {KIND_DATA, 8'h82},
        // sleep out, then let the panel wake
        {KIND_COMM, 8'h11},
        {KIND_WAIT, 8'hFF},
        // display on, inversion on, tearing off
        {KIND_COMM, 8'h29},
        {KIND_COMM, 8'h21},
        {KIND_COMM, 8'h34},
        {KIND_WAIT, 8'hFF},
        // column window 0..319
        {KIND_COMM, 8'h2A},
        {KIND_DATA, 8'h00},
        {KIND_DATA, 8'h00},
        {KIND_DATA, 8'h01},
        {KIND_DATA, 8'h3F},
        // page window 0..479
        {KIND_COMM, 8'h2B},
        {KIND_DATA, 8'h00},
        {KIND_DATA, 8'h00},
        {KIND_DATA, 8'h01},
        {KIND_DATA, 8'hDF},
        {KIND_WAIT, 8'hFF},
        // memory write, ready for pixels
        {KIND_COMM, 8'h2C}
    };

    seq_index_t index;
    // set one cycle after reset so busy stays low in reset
    logic       armed;
    seq_entry_t cur_entry;
    kind_t      cur_kind;
    byte_t      cur_payload;
    logic       step;

    assign busy = armed & enable & (index < TABLE_END);

    assign cur_entry   = SEQ_TABLE[index[TABLE_AW-1:0]];
    assign cur_kind    = cur_entry[ENTRY_W-1 -: KIND_W];
    assign cur_payload = cur_entry[BYTE_W-1:0];

    // shifter and timer idle, and no strobe went out last cycle
    assign step = busy & ~tx_busy & ~tx_start & delay_free & ~delay_load;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            armed      <= 1'b0;
            index      <= '0;
            tx_start   <= 1'b0;
            delay_load <= 1'b0;
        end
        else
        begin
            armed      <= 1'b1;
            tx_start   <= 1'b0;
            delay_load <= 1'b0;
            if (step)
            begin
                if (cur_kind[KIND_WAIT_BIT])
                begin
                    delay_load <= 1'b1;
                end
                else
                begin
                    tx_start <= 1'b1;
                end
                index <= index + 1'b1;
            end
        end
    end

    // payload held until the next strobe
    always_ff @(posedge clk)
    begin
        if (step)
        begin
            if (cur_kind[KIND_WAIT_BIT])
            begin
                delay_ms <= ms_t'(cur_payload);
            end
            else
            begin
                tx_dc   <= cur_kind[KIND_DC_BIT];
                tx_data <= cur_payload;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tft_pkg.sv
// ################################################
// tft package: shared widths, types, table layout
// ################################################

`default_nettype none

package tft_pkg;

    // basic field widths
    localparam int BYTE_W  = 8;
    localparam int MS_W    = 8;
    localparam int KIND_W  = 2;
    localparam int ENTRY_W = KIND_W + BYTE_W;

    // command or data byte on the serial link
    typedef logic [BYTE_W-1:0] byte_t;

    // delay length in milliseconds
    typedef logic [MS_W-1:0] ms_t;

    // entry kind, upper field of a table entry
    typedef logic [KIND_W-1:0] kind_t;

    // one table entry: {kind, byte or delay}
    typedef logic [ENTRY_W-1:0] seq_entry_t;

    localparam kind_t KIND_COMM = 2'd0;
    localparam kind_t KIND_DATA = 2'd1;
    localparam kind_t KIND_WAIT = 2'd2;

    // top kind bit marks a wait, low kind bit is the d/c level of a byte
    localparam int KIND_WAIT_BIT = 1;
    localparam int KIND_DC_BIT   = 0;

    // init table length and index width
    localparam int SEQ_LEN     = 46;
    localparam int SEQ_INDEX_W = 8;

    typedef logic [SEQ_INDEX_W-1:0] seq_index_t;

endpackage

`default_nettype wire

// File: hdl/tft_spi.sv
// ################################################
// tft_spi: serial byte shifter, mode 0, msb first
// ################################################

`timescale 1ns/1ps
`default_nettype none

module tft_spi
    import tft_pkg::*;
#(
    parameter int SCLK_DIV = 2
)
(
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire logic  dc,
    input  wire byte_t data,
    output logic       busy,
    output logic       cs,
    output logic       sclk,
    output logic       mosi,
    output logic       tft_dc
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_DIV - 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_FINISH
    } spi_state_t;

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    byte_t            shreg;

    assign busy = (state != S_IDLE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= S_IDLE;
            cs      <= 1'b1;
            sclk    <= 1'b0;
            mosi    <= 1'b0;
            tft_dc  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (start)
                    begin
                        // first bit is on the line when cs falls
                        cs      <= 1'b0;
                        mosi    <= data[BYTE_W-1];
                        tft_dc  <= dc;
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= S_SHIFT;
                    end
                end
                S_SHIFT:
                begin
                    if (div_cnt == DIV_LAST)
                    begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                        if (sclk)
                        begin
                            // falling edge, move to the next bit
                            if (bit_cnt == 3'd7)
                            begin
                                state <= S_FINISH;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 1'b1;
                                mosi    <= shreg[BYTE_W-2];
                            end
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                S_FINISH:
                begin
                    cs    <= 1'b1;
                    state <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // shift register, loaded with the byte and moved on each falling edge
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && start)
        begin
            shreg <= data;
        end
        else if (state == S_SHIFT && div_cnt == DIV_LAST && sclk)
        begin
            shreg <= {shreg[BYTE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: tft_ctrl.f
hdl/tft_pkg.sv
hdl/ms_delay.sv
hdl/tft_init.sv
hdl/tft_spi.sv
hdl/tft_ctrl_top.sv
bench/tft_ctrl_properties.sv
bench/tft_ctrl_tb.sv
